// File: mycpu.f
mips_isa_pkg.sv
cpu_bus_pkg.sv
stage_ifs.sv
fetch_unit.sv
exec_unit.sv
retire_unit.sv
mycpu_top.sv
tb_properties.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= mycpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_top.sv
/*
 * Testbench for the core. Runs a random program of ALU instructions
 * out of an AXI4-Lite memory model with random delays and bus errors,
 * and checks every retired instruction on the trace ports against a
 * reference model of the instruction set.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_top;

    localparam int PROG_LEN   = 200;
    localparam int INIT_LEN   = 31;   // one ori per register up front
    localparam int WAIT_LIMIT = 100;  // cycles per wait
    localparam cpu_bus_pkg::axi_resp_t RESP_SLVERR = 2'b10;

    logic                           aclk;
    logic                           rst_n;
    logic [cpu_bus_pkg::ADDR_W-1:0] araddr;
    logic                           arvalid;
    logic                           arready;
    logic [cpu_bus_pkg::DATA_W-1:0] rdata;
    cpu_bus_pkg::axi_resp_t         rresp;
    logic                           rvalid;
    logic                           rready;
    mips_isa_pkg::word_t            debug_wb_pc;
    mips_isa_pkg::word_t            debug_wb_rf_wdata;
    logic [3:0]                     debug_wb_rf_wen;
    mips_isa_pkg::reg_idx_t         debug_wb_rf_wnum;

    mips_isa_pkg::word_t prog [PROG_LEN];
    logic                err_sel [PROG_LEN];  // fetch answered with SLVERR
    mips_isa_pkg::word_t model_regs [mips_isa_pkg::NUM_REGS];
    int                  errors;
    int                  retired;
    int                  fetches;
    logic                timed_out;

    mycpu_top dut0 (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .araddr            (araddr),
        .arvalid           (arvalid),
        .arready           (arready),
        .rdata             (rdata),
        .rresp             (rresp),
        .rvalid            (rvalid),
        .rready            (rready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic mips_isa_pkg::reg_idx_t dest_of(input mips_isa_pkg::word_t w);
        return (w[31:26] == mips_isa_pkg::OP_SPECIAL) ? w[15:11] : w[20:16];
    endfunction

    // random alu instruction that reads the previous destination half the time
    function automatic mips_isa_pkg::word_t make_instr(input mips_isa_pkg::reg_idx_t prev_dst);
        int                     kind;
        mips_isa_pkg::reg_idx_t rs;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::reg_idx_t rd;
        logic [4:0]             sa;
        logic [15:0]            imm;
        logic [5:0]             fn;
        logic [5:0]             op;
        kind = $urandom_range(0, 16);
        rs   = 5'($urandom_range(0, 31));
        rt   = 5'($urandom_range(0, 31));
        rd   = 5'($urandom_range(0, 31));
        imm  = 16'($urandom);
        sa   = 5'd0;
        fn   = 6'd0;
        op   = mips_isa_pkg::OP_SPECIAL;
        if ($urandom_range(0, 1) == 1) rs = prev_dst;
        if ($urandom_range(0, 3) == 0) rt = prev_dst;
        case (kind)
            0: begin
                fn = mips_isa_pkg::FN_SLL;
                sa = 5'($urandom_range(0, 31));
            end
            1: begin
                fn = mips_isa_pkg::FN_SRL;
                sa = 5'($urandom_range(0, 31));
            end
            2:  fn = mips_isa_pkg::FN_ADDU;
            3:  fn = mips_isa_pkg::FN_SUBU;
            4:  fn = mips_isa_pkg::FN_AND;
            5:  fn = mips_isa_pkg::FN_OR;
            6:  fn = mips_isa_pkg::FN_XOR;
            7:  fn = mips_isa_pkg::FN_NOR;
            8:  fn = mips_isa_pkg::FN_SLT;
            9:  fn = mips_isa_pkg::FN_SLTU;
            10: op = mips_isa_pkg::OP_ADDIU;
            11: op = mips_isa_pkg::OP_SLTI;
            12: op = mips_isa_pkg::OP_SLTIU;
            13: op = mips_isa_pkg::OP_ANDI;
            14: op = mips_isa_pkg::OP_ORI;
            15: op = mips_isa_pkg::OP_XORI;
            default: op = mips_isa_pkg::OP_LUI;
        endcase
        if (kind < 10) return {op, rs, rt, rd, sa, fn};
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        mips_isa_pkg::reg_idx_t prev;
        prev = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i < INIT_LEN) begin
                // ori r(i+1), r0, imm so that every register holds a known value
                prog[i] = {mips_isa_pkg::OP_ORI, 5'd0, 5'(i + 1), 16'($urandom)};
                err_sel[i] = 1'b0;
            end else begin
                prog[i] = make_instr(prev);
                err_sel[i] = ($urandom_range(0, 11) == 0);
            end
            prev = dest_of(prog[i]);
        end
        for (int r = 0; r < mips_isa_pkg::NUM_REGS; r++) model_regs[r] = '0;
    endtask

    // executes program entry idx on the model register file
    function automatic void ref_execute(
        input  int                      idx,
        output mips_isa_pkg::word_t     pc,
        output logic                    wen,
        output mips_isa_pkg::reg_idx_t  wnum,
        output mips_isa_pkg::word_t     wdata
    );
        mips_isa_pkg::word_t w;
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t simm;
        mips_isa_pkg::word_t zimm;
        logic                known;
        w     = err_sel[idx] ? '0 : prog[idx];  // bus error reads as sll r0
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        simm  = {{16{w[15]}}, w[15:0]};
        zimm  = {16'h0000, w[15:0]};
        known = 1'b1;
        wnum  = w[20:16];
        wdata = '0;
        pc    = cpu_bus_pkg::RESET_PC + cpu_bus_pkg::INSTR_BYTES * 32'(idx);
        if (w[31:26] == mips_isa_pkg::OP_SPECIAL) begin
            wnum = w[15:11];
            case (w[5:0])
                mips_isa_pkg::FN_SLL:  wdata = b << w[10:6];
                mips_isa_pkg::FN_SRL:  wdata = b >> w[10:6];
                mips_isa_pkg::FN_ADDU: wdata = a + b;
                mips_isa_pkg::FN_SUBU: wdata = a - b;
                mips_isa_pkg::FN_AND:  wdata = a & b;
                mips_isa_pkg::FN_OR:   wdata = a | b;
                mips_isa_pkg::FN_XOR:  wdata = a ^ b;
                mips_isa_pkg::FN_NOR:  wdata = ~(a | b);
                mips_isa_pkg::FN_SLT:  wdata = {31'b0, $signed(a) < $signed(b)};
                mips_isa_pkg::FN_SLTU: wdata = {31'b0, a < b};
                default:               known = 1'b0;
            endcase
        end else begin
            case (w[31:26])
                mips_isa_pkg::OP_ADDIU: wdata = a + simm;
                mips_isa_pkg::OP_SLTI:  wdata = {31'b0, $signed(a) < $signed(simm)};
                mips_isa_pkg::OP_SLTIU: wdata = {31'b0, a < simm};
                mips_isa_pkg::OP_ANDI:  wdata = a & zimm;
                mips_isa_pkg::OP_ORI:   wdata = a | zimm;
                mips_isa_pkg::OP_XORI:  wdata = a ^ zimm;
                mips_isa_pkg::OP_LUI:   wdata = {w[15:0], 16'h0000};
                default:                known = 1'b0;
            endcase
        end
        wen = known && (wnum != 5'd0);
        if (wen) model_regs[wnum] = wdata;
    endfunction

    // memory slave serving one read at a time
    task automatic serve_reads();
        int                  waited;
        int                  idx;
        mips_isa_pkg::word_t offs;
        mips_isa_pkg::word_t exp_addr;
        while (!timed_out) begin
            waited = 0;
            while (!arvalid && !timed_out) begin
                @(negedge aclk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    errors++;
                    timed_out = 1'b1;
                    $display("timeout while waiting for the core to request a fetch");
                end
            end
            if (!timed_out) begin
                exp_addr = cpu_bus_pkg::RESET_PC + cpu_bus_pkg::INSTR_BYTES * 32'(fetches);
                if (araddr !== exp_addr) begin
                    errors++;
                    $display("[FAIL] araddr: got %h, expected %h", araddr, exp_addr);
                end
                offs = araddr - cpu_bus_pkg::RESET_PC;
                idx  = int'(offs >> 2);
                fetches++;
                repeat ($urandom_range(0, 3)) @(negedge aclk);
                arready = 1'b1;  // arvalid is held so the next edge transfers
                @(negedge aclk);
                arready = 1'b0;
                repeat ($urandom_range(0, 3)) @(negedge aclk);
                rvalid = 1'b1;
                rdata  = '0;     // past the program end
                rresp  = cpu_bus_pkg::RESP_OKAY;
                if (offs < 32'(PROG_LEN * 4)) begin
                    rdata = prog[idx];
                    rresp = err_sel[idx] ? RESP_SLVERR : cpu_bus_pkg::RESP_OKAY;
                end
                waited = 0;
                while (!rready && !timed_out) begin
                    @(negedge aclk);
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        errors++;
                        timed_out = 1'b1;
                        $display("timeout while read data waited for rready");
                    end
                end
                @(negedge aclk);
                rvalid = 1'b0;
            end
        end
    endtask

    // compares each change of debug_wb_pc against the model
    task automatic check_retires();
        mips_isa_pkg::word_t    last_pc;
        mips_isa_pkg::word_t    e_pc;
        mips_isa_pkg::word_t    e_wdata;
        mips_isa_pkg::reg_idx_t e_wnum;
        logic                   e_wen;
        int                     waited;
        last_pc = debug_wb_pc;
        while (retired < PROG_LEN && !timed_out) begin
            waited = 0;
            while (debug_wb_pc == last_pc && !timed_out) begin
                @(negedge aclk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    errors++;
                    timed_out = 1'b1;
                    $display("timeout: instruction %0d never retired", retired);
                end
            end
            if (!timed_out) begin
                last_pc = debug_wb_pc;
                ref_execute(retired, e_pc, e_wen, e_wnum, e_wdata);
                if (debug_wb_pc !== e_pc) begin
                    errors++;
                    $display("[FAIL] debug_wb_pc: got %h, expected %h", debug_wb_pc, e_pc);
                end
                if (debug_wb_rf_wen !== {4{e_wen}}) begin
                    errors++;
                    $display("[FAIL] debug_wb_rf_wen: got %h, expected %h",
                             debug_wb_rf_wen, {4{e_wen}});
                end
                if (debug_wb_rf_wnum !== e_wnum) begin
                    errors++;
                    $display("[FAIL] debug_wb_rf_wnum: got %h, expected %h",
                             debug_wb_rf_wnum, e_wnum);
                end
                if (debug_wb_rf_wdata !== e_wdata) begin
                    errors++;
                    $display("[FAIL] debug_wb_rf_wdata: got %h, expected %h",
                             debug_wb_rf_wdata, e_wdata);
                end
                retired++;
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        arready   = 1'b0;
        rdata     = '0;
        rresp     = cpu_bus_pkg::RESP_OKAY;
        rvalid    = 1'b0;
        errors    = 0;
        retired   = 0;
        fetches   = 0;
        timed_out = 1'b0;
        void'($urandom(60));
        build_program();
        repeat (8) @(negedge aclk);
        // read channel idle and trace cleared while in reset
        if (arvalid !== 1'b0) begin
            errors++;
            $display("[FAIL] arvalid: got %h, expected %h", arvalid, 1'b0);
        end
        if (rready !== 1'b0) begin
            errors++;
            $display("[FAIL] rready: got %h, expected %h", rready, 1'b0);
        end
        if (debug_wb_pc !== '0) begin
            errors++;
            $display("[FAIL] debug_wb_pc: got %h, expected %h", debug_wb_pc, 32'h0);
        end
        if (debug_wb_rf_wdata !== '0) begin
            errors++;
            $display("[FAIL] debug_wb_rf_wdata: got %h, expected %h",
                     debug_wb_rf_wdata, 32'h0);
        end
        if (debug_wb_rf_wen !== '0) begin
            errors++;
            $display("[FAIL] debug_wb_rf_wen: got %h, expected %h", debug_wb_rf_wen, 4'h0);
        end
        if (debug_wb_rf_wnum !== '0) begin
            errors++;
            $display("[FAIL] debug_wb_rf_wnum: got %h, expected %h", debug_wb_rf_wnum, 5'h0);
        end
        rst_n = 1'b1;
        fork
            serve_reads();
        join_none
        check_retires();
        $display("retired %0d of %0d instructions, %0d errors", retired, PROG_LEN, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_properties.sv
/*
 * Concurrent assertions on the core's top level ports,
 * bound into every mycpu_top instance.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_properties (
    input logic                           aclk,
    input logic                           rst_n,
    input logic [cpu_bus_pkg::ADDR_W-1:0] araddr,
    input logic                           arvalid,
    input logic                           arready,
    input logic [3:0]                     debug_wb_rf_wen,
    input mips_isa_pkg::reg_idx_t         debug_wb_rf_wnum
);

    // address held until accepted
    ar_addr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> $stable(araddr))
        else $error("araddr changed while arvalid waited for arready");

    ar_addr_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid |-> araddr[1:0] == 2'b00)
        else $error("araddr is not word aligned");

    wen_whole_word: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else $error("debug_wb_rf_wen is neither zero nor all ones");

    no_r0_write: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("write to register 0 on the trace");

endmodule

bind mycpu_top tb_properties props0 (
    .aclk             (aclk),
    .rst_n            (rst_n),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

// File: mycpu_top.sv
/*
 * Top level of the core.
 * Connects the fetcher, the execute stage and the retire stage to the
 * AXI4-Lite read port and to the golden trace outputs.
 */
`timescale 1ns/10ps
`default_nettype none

module mycpu_top (
    input  logic                           aclk,
    input  logic                           rst_n,
    output logic [cpu_bus_pkg::ADDR_W-1:0] araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [cpu_bus_pkg::DATA_W-1:0] rdata,
    input  cpu_bus_pkg::axi_resp_t         rresp,
    input  logic                           rvalid,
    output logic                           rready,
    output mips_isa_pkg::word_t            debug_wb_pc,
    output mips_isa_pkg::word_t            debug_wb_rf_wdata,
    output logic [3:0]                     debug_wb_rf_wen,
    output mips_isa_pkg::reg_idx_t         debug_wb_rf_wnum
);

    logic                fetch_valid;
    mips_isa_pkg::word_t fetch_pc;
    mips_isa_pkg::word_t fetch_instr;

    exe_wb_if  ewb ();
    regread_if rr ();

    fetch_unit u_fetch_unit (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    exec_unit u_exec_unit (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .rr          (rr.reader),
        .ewb         (ewb.exe)
    );

    retire_unit u_retire_unit (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .ewb               (ewb.wb),
        .rf                (rr.file),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

// File: retire_unit.sv
/*
 * Retire stage of the core.
 * Holds the register file, writes results back and drives the
 * golden trace ports, one update per retired instruction.
 */
`timescale 1ns/10ps
`default_nettype none

module retire_unit (
    input  logic                   aclk,
    input  logic                   rst_n,
    exe_wb_if.wb                   ewb,
    regread_if.file                rf,
    output mips_isa_pkg::word_t    debug_wb_pc,
    output mips_isa_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]             debug_wb_rf_wen,
    output mips_isa_pkg::reg_idx_t debug_wb_rf_wnum
);

    mips_isa_pkg::word_t regs [mips_isa_pkg::NUM_REGS];

    // r0 reads as zero
    assign rf.rs_data = (rf.rs_addr == '0) ? '0 : regs[rf.rs_addr];
    assign rf.rt_data = (rf.rt_addr == '0) ? '0 : regs[rf.rt_addr];

    always_ff @(posedge aclk) begin
        if (ewb.valid && ewb.wen) begin
            regs[ewb.wnum] <= ewb.wdata;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            debug_wb_pc       <= '0;
            debug_wb_rf_wdata <= '0;
            debug_wb_rf_wen   <= '0;
            debug_wb_rf_wnum  <= '0;
        end else if (ewb.valid) begin
            debug_wb_pc       <= ewb.pc;
            debug_wb_rf_wdata <= ewb.wdata;
            debug_wb_rf_wen   <= {4{ewb.wen}};  // whole word or nothing
            debug_wb_rf_wnum  <= ewb.wnum;
        end
    end

endmodule

`default_nettype wire

// File: exec_unit.sv
/*
 * Execute stage of the core.
 * Decodes the fetched word, reads its sources with a bypass from the
 * result register, computes the ALU result and registers it for retire.
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                fetch_valid,
    input  mips_isa_pkg::word_t fetch_pc,
    input  mips_isa_pkg::word_t fetch_instr,
    regread_if.reader           rr,
    exe_wb_if.exe               ewb
);

    mips_isa_pkg::instr_u   ins;
    mips_isa_pkg::word_t    rs_val;
    mips_isa_pkg::word_t    rt_val;
    mips_isa_pkg::word_t    imm_sext;
    mips_isa_pkg::word_t    imm_zext;
    mips_isa_pkg::word_t    alu_res;
    mips_isa_pkg::reg_idx_t dst;
    logic                   wr_ok;  // known instruction

    assign ins = fetch_instr;

    // rs and rt sit at the same bits in both views
    assign rr.rs_addr = ins.r_view.rs;
    assign rr.rt_addr = ins.r_view.rt;

    // bypass the instruction still held in the result register
    assign rs_val = (ewb.valid && ewb.wen && ewb.wnum == ins.r_view.rs) ?
                    ewb.wdata : rr.rs_data;
    assign rt_val = (ewb.valid && ewb.wen && ewb.wnum == ins.r_view.rt) ?
                    ewb.wdata : rr.rt_data;

    assign imm_sext = {{16{ins.i_view.imm[15]}}, ins.i_view.imm};
    assign imm_zext = {16'h0000, ins.i_view.imm};

    always_comb begin
        alu_res = '0;
        wr_ok   = 1'b1;
        dst     = ins.i_view.rt;  // immediate forms write rt
        case (ins.r_view.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                dst = ins.r_view.rd;
                case (ins.r_view.funct)
                    mips_isa_pkg::FN_SLL:  alu_res = rt_val << ins.r_view.shamt;
                    mips_isa_pkg::FN_SRL:  alu_res = rt_val >> ins.r_view.shamt;
                    mips_isa_pkg::FN_ADDU: alu_res = rs_val + rt_val;
                    mips_isa_pkg::FN_SUBU: alu_res = rs_val - rt_val;
                    mips_isa_pkg::FN_AND:  alu_res = rs_val & rt_val;
                    mips_isa_pkg::FN_OR:   alu_res = rs_val | rt_val;
                    mips_isa_pkg::FN_XOR:  alu_res = rs_val ^ rt_val;
                    mips_isa_pkg::FN_NOR:  alu_res = ~(rs_val | rt_val);
                    mips_isa_pkg::FN_SLT: begin
                        alu_res = {31'b0, $signed(rs_val) < $signed(rt_val)};
                    end
                    mips_isa_pkg::FN_SLTU: begin
                        alu_res = {31'b0, rs_val < rt_val};
                    end
                    default: wr_ok = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: alu_res = rs_val + imm_sext;
            mips_isa_pkg::OP_SLTI: begin
                alu_res = {31'b0, $signed(rs_val) < $signed(imm_sext)};
            end
            mips_isa_pkg::OP_SLTIU: begin
                alu_res = {31'b0, rs_val < imm_sext};  // unsigned compare
            end
            mips_isa_pkg::OP_ANDI:  alu_res = rs_val & imm_zext;
            mips_isa_pkg::OP_ORI:   alu_res = rs_val | imm_zext;
            mips_isa_pkg::OP_XORI:  alu_res = rs_val ^ imm_zext;
            mips_isa_pkg::OP_LUI:   alu_res = {ins.i_view.imm, 16'h0000};
            default:                wr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ewb.valid <= 1'b0;
            ewb.wen   <= 1'b0;
        end else begin
            ewb.valid <= fetch_valid;
            if (fetch_valid) begin
                ewb.wen <= wr_ok && (dst != '0);  // r0 is never written
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (fetch_valid) begin
            ewb.pc    <= fetch_pc;
            ewb.wnum  <= dst;
            ewb.wdata <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
/*
 * Instruction fetcher on an AXI4-Lite read channel.
 * Issues one read at a time from the PC, steps the PC by one word after
 * each data beat and presents the fetched word for one cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                     aclk,
    input  logic                     rst_n,
    output mips_isa_pkg::word_t      araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  mips_isa_pkg::word_t      rdata,
    input  cpu_bus_pkg::axi_resp_t   rresp,
    input  logic                     rvalid,
    output logic                     rready,
    output logic                     fetch_valid,
    output mips_isa_pkg::word_t      fetch_pc,
    output mips_isa_pkg::word_t      fetch_instr
);

    typedef enum logic {
        S_ADDR,  // waiting for the address handshake
        S_DATA   // waiting for the read data
    } fetch_state_e;

    fetch_state_e        state;
    mips_isa_pkg::word_t pc;
    logic                ar_xfer;
    logic                r_xfer;

    assign ar_xfer = arvalid & arready;
    assign r_xfer  = rvalid & rready;

    assign araddr = pc;  // pc only moves on an R beat, so stable during AR
    assign rready = (state == S_DATA);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_ADDR;
            arvalid <= 1'b0;
            pc      <= cpu_bus_pkg::RESET_PC;
        end else begin
            case (state)
                S_ADDR: begin
                    if (ar_xfer) begin
                        arvalid <= 1'b0;
                        state   <= S_DATA;
                    end else begin
                        arvalid <= 1'b1;  // first request after reset
                    end
                end
                S_DATA: begin
                    if (r_xfer) begin
                        arvalid <= 1'b1;  // next request right away
                        pc      <= pc + cpu_bus_pkg::INSTR_BYTES;
                        state   <= S_ADDR;
                    end
                end
                default: begin
                    state <= S_ADDR;
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= r_xfer;
        end
    end

    // instruction buffer
    always_ff @(posedge aclk) begin
        if (r_xfer) begin
            fetch_pc <= pc;
            // error response retires as sll r0, harmless
            fetch_instr <= (rresp == cpu_bus_pkg::RESP_OKAY) ? rdata : '0;
        end
    end

endmodule

`default_nettype wire

// File: stage_ifs.sv
/*
 * Interfaces between the core units.
 * exe_wb_if carries the execute result to the retire unit,
 * regread_if carries register reads from execute into the register file.
 */
`timescale 1ns/10ps
`default_nettype none

interface exe_wb_if;
    logic                          valid;  // one cycle per retiring instruction
    logic [cpu_bus_pkg::ADDR_W-1:0] pc;
    logic                          wen;    // already masked for r0
    mips_isa_pkg::reg_idx_t        wnum;
    mips_isa_pkg::word_t           wdata;

    modport exe (
        output valid, pc, wen, wnum, wdata
    );

    modport wb (
        input valid, pc, wen, wnum, wdata
    );
endinterface

interface regread_if;
    mips_isa_pkg::reg_idx_t rs_addr;
    mips_isa_pkg::reg_idx_t rt_addr;
    mips_isa_pkg::word_t    rs_data;  // combinational from the file
    mips_isa_pkg::word_t    rt_data;

    modport reader (
        output rs_addr, rt_addr,
        input  rs_data, rt_data
    );

    modport file (
        input  rs_addr, rt_addr,
        output rs_data, rt_data
    );
endinterface

`default_nettype wire

// File: cpu_bus_pkg.sv
/*
 * Bus level constants for the instruction fetch port.
 * Address and data widths, the boot address and AXI response codes.
 */
`default_nettype none

package cpu_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] RESET_PC    = 32'hbfc0_0000;  // boot rom base
    localparam logic [ADDR_W-1:0] INSTR_BYTES = 4;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: mips_isa_pkg.sv
/*
 * Instruction set definitions for the MIPS subset executed by the core.
 * Holds register and word types, major opcode and function codes and
 * the instruction word union that the decoder reads in two formats.
 */
`default_nettype none

package mips_isa_pkg;

    localparam int NUM_REGS = 32;  // general purpose registers

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    // same 32 bits, register or immediate layout
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } instr_u;

endpackage

`default_nettype wire
